// File: rtl/hdc_pkg.sv
package hdc_pkg;

    // hypervector and memory sizes
    localparam int HV_DIM = 64;
    localparam int MEM_DEPTH = 512;
    localparam int ADDR_W = $clog2(MEM_DEPTH);

    // hardware threads, issued round robin
    localparam int THREADS = 10;
    localparam int THREAD_W = 4;

    // rotation amount taken from the low instruction field
    localparam int ROT_W = $clog2(HV_DIM);

    localparam int INSTR_W = 16;

    // instruction bit positions
    localparam int BIT_ADDR = 15;
    localparam int BIT_PERMUTE = 14;
    localparam int BIT_LOAD_XOR = 13;
    localparam int BIT_STORE_WB = 12;
    localparam int BIT_MOVE = 11;
    localparam int BIT_LAST = 10;

    typedef logic [HV_DIM-1:0] hv_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [THREAD_W-1:0] thread_t;
    typedef logic [INSTR_W-1:0] instr_t;

    // decoded operation
    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_LOAD    = 3'd1,
        OP_XOR     = 3'd2,
        OP_STORE   = 3'd3,
        OP_MOVE    = 3'd4,
        OP_LAST    = 3'd5,
        OP_WB_ITEM = 3'd6
    } op_e;

endpackage

// File: rtl/hdc_exec_if.sv
`timescale 1ns/1ps

interface hdc_exec_if;

    // one decoded instruction in the execute stage
    logic                       ex_valid;
    hdc_pkg::op_e               op;
    hdc_pkg::thread_t           thread;
    hdc_pkg::mem_addr_t         addr;
    logic                       permute;
    logic [hdc_pkg::ROT_W-1:0]  rot;

    modport ctrl (
        output ex_valid,
        output op,
        output thread,
        output addr,
        output permute,
        output rot
    );

    modport dp (
        input ex_valid,
        input op,
        input thread,
        input addr,
        input permute,
        input rot
    );

endinterface

// File: rtl/item_memory.sv
`timescale 1ns/1ps

module item_memory (
    input  logic                clk,
    input  hdc_pkg::mem_addr_t  rd_addr,
    output hdc_pkg::hv_t        rd_data,
    input  logic                ext_wr,
    input  hdc_pkg::mem_addr_t  ext_addr,
    input  hdc_pkg::hv_t        ext_data,
    input  logic                wb_wr,
    input  hdc_pkg::mem_addr_t  wb_addr,
    input  hdc_pkg::hv_t        wb_data
);

    hdc_pkg::hv_t mem [hdc_pkg::MEM_DEPTH];

    // single write port, write-back beats the external write
    always_ff @(posedge clk) begin
        if (wb_wr) begin
            mem[wb_addr] <= wb_data;
        end else if (ext_wr) begin
            mem[ext_addr] <= ext_data;
        end
    end

    // read every cycle, old data on a same-edge write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    a_wb_addr_range: assert property (
        @(posedge clk)
        wb_wr |-> (!$isunknown(wb_addr) && (int'(wb_addr) < hdc_pkg::MEM_DEPTH))
    );

    a_ext_addr_range: assert property (
        @(posedge clk)
        ext_wr |-> (!$isunknown(ext_addr) && (int'(ext_addr) < hdc_pkg::MEM_DEPTH))
    );

endmodule

// File: rtl/thread_regbank.sv
`timescale 1ns/1ps

module thread_regbank (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    hdc_exec_if.dp          ex,
    output hdc_pkg::hv_t    rd_data,
    input  logic            wr_en,
    input  hdc_pkg::hv_t    wr_data
);

    hdc_pkg::hv_t regs [hdc_pkg::THREADS];

    assign rd_data = regs[ex.thread];

    // dropping run wipes every thread
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            for (int i = 0; i < hdc_pkg::THREADS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex.thread] <= wr_data;
        end
    end

endmodule

// File: rtl/hv_rotate.sv
`timescale 1ns/1ps

module hv_rotate (
    hdc_exec_if.dp          ex,
    input  hdc_pkg::hv_t    src,
    output hdc_pkg::hv_t    operand
);

    logic [2*hdc_pkg::HV_DIM-1:0] doubled;
    hdc_pkg::hv_t                 rotated;

    // upper half of the shifted pair is the cyclic rotation
    always_comb begin
        doubled = {src, src} << ex.rot;
        rotated = doubled[2*hdc_pkg::HV_DIM-1 -: hdc_pkg::HV_DIM];
    end

    assign operand = ex.permute ? rotated : src;

endmodule

// File: rtl/hdc_execute.sv
`timescale 1ns/1ps

module hdc_execute (
    input  logic                clk,
    input  logic                rst,
    hdc_exec_if.dp              ex,
    input  hdc_pkg::hv_t        mem_data,
    input  hdc_pkg::hv_t        a_data,
    input  hdc_pkg::hv_t        operand,
    output logic                a_wr,
    output logic                b_wr,
    output hdc_pkg::hv_t        b_wr_data,
    output logic                wb_wr,
    output hdc_pkg::mem_addr_t  wb_addr,
    output logic                store,
    output hdc_pkg::hv_t        result,
    output logic                last
);

    logic is_load;
    logic is_store;

    assign is_load  = ex.ex_valid && (ex.op == hdc_pkg::OP_LOAD);
    assign is_store = ex.ex_valid && (ex.op == hdc_pkg::OP_STORE);

    // bank and memory writes land at the end of the execute cycle
    assign a_wr  = ex.ex_valid && (ex.op == hdc_pkg::OP_MOVE);
    assign b_wr  = is_load || (ex.ex_valid && (ex.op == hdc_pkg::OP_XOR));
    assign wb_wr = ex.ex_valid && (ex.op == hdc_pkg::OP_WB_ITEM);

    assign wb_addr   = ex.addr;
    assign b_wr_data = is_load ? mem_data : (a_data ^ operand);

    // one-cycle pulses, result held at zero between stores
    always_ff @(posedge clk) begin
        if (rst) begin
            store  <= 1'b0;
            last   <= 1'b0;
            result <= '0;
        end else begin
            store  <= is_store;
            last   <= ex.ex_valid && (ex.op == hdc_pkg::OP_LAST);
            result <= is_store ? operand : '0;
        end
    end

    a_store_last_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(store && last)
    );

endmodule

// File: rtl/hdc_decode.sv
`timescale 1ns/1ps

module hdc_decode (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            instr_valid,
    input  hdc_pkg::instr_t instr,
    hdc_exec_if.ctrl        ex
);

    hdc_pkg::op_e       dec_op;
    hdc_pkg::thread_t   thread_cnt;
    logic               accept;

    assign accept = instr_valid && run;

    // address-form instructions first, then priority over bits 13..10
    always_comb begin
        dec_op = hdc_pkg::OP_NOP;
        if (instr[hdc_pkg::BIT_ADDR]) begin
            if (instr[hdc_pkg::BIT_LOAD_XOR]) begin
                dec_op = hdc_pkg::OP_LOAD;
            end else if (instr[hdc_pkg::BIT_STORE_WB]) begin
                dec_op = hdc_pkg::OP_WB_ITEM;
            end
        end else begin
            if (instr[hdc_pkg::BIT_LOAD_XOR]) begin
                dec_op = hdc_pkg::OP_XOR;
            end else if (instr[hdc_pkg::BIT_STORE_WB]) begin
                dec_op = hdc_pkg::OP_STORE;
            end else if (instr[hdc_pkg::BIT_MOVE]) begin
                dec_op = hdc_pkg::OP_MOVE;
            end else if (instr[hdc_pkg::BIT_LAST]) begin
                dec_op = hdc_pkg::OP_LAST;
            end
        end
    end

    // round robin thread counter, restarts at 0 when run drops
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            thread_cnt <= '0;
        end else if (accept) begin
            if (thread_cnt == hdc_pkg::thread_t'(hdc_pkg::THREADS - 1)) begin
                thread_cnt <= '0;
            end else begin
                thread_cnt <= thread_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            ex.ex_valid <= 1'b0;
        end else begin
            ex.ex_valid <= instr_valid;
        end
    end

    // decoded fields, qualified by ex_valid downstream
    always_ff @(posedge clk) begin
        if (accept) begin
            ex.op      <= dec_op;
            ex.thread  <= thread_cnt;
            ex.addr    <= instr[hdc_pkg::ADDR_W-1:0];
            ex.permute <= instr[hdc_pkg::BIT_PERMUTE];
            ex.rot     <= instr[hdc_pkg::ROT_W-1:0];
        end
    end

    // banks are indexed by this, so an overflow would corrupt state
    a_thread_range: assert property (
        @(posedge clk) disable iff (rst)
        ex.ex_valid |-> (ex.thread < hdc_pkg::thread_t'(hdc_pkg::THREADS))
    );

endmodule

// File: rtl/hdc_core.sv
`timescale 1ns/1ps

module hdc_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                instr_valid,
    input  hdc_pkg::instr_t     instr,
    input  logic                item_wr,
    input  hdc_pkg::mem_addr_t  item_addr,
    input  hdc_pkg::hv_t        item_data,
    output logic                store,
    output hdc_pkg::hv_t        result,
    output logic                last
);

    hdc_exec_if ex ();

    hdc_pkg::hv_t       mem_data;
    hdc_pkg::hv_t       a_data;
    hdc_pkg::hv_t       b_data;
    hdc_pkg::hv_t       operand;
    hdc_pkg::hv_t       b_wr_data;
    hdc_pkg::mem_addr_t wb_addr;
    logic               a_wr;
    logic               b_wr;
    logic               wb_wr;

    hdc_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ex          (ex.ctrl)
    );

    // read address is the raw low field, sampled with the instruction
    item_memory i_item_memory (
        .clk      (clk),
        .rd_addr  (instr[hdc_pkg::ADDR_W-1:0]),
        .rd_data  (mem_data),
        .ext_wr   (item_wr),
        .ext_addr (item_addr),
        .ext_data (item_data),
        .wb_wr    (wb_wr),
        .wb_addr  (wb_addr),
        .wb_data  (operand)
    );

    thread_regbank bank_a (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .ex      (ex.dp),
        .rd_data (a_data),
        .wr_en   (a_wr),
        .wr_data (operand)
    );

    thread_regbank bank_b (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .ex      (ex.dp),
        .rd_data (b_data),
        .wr_en   (b_wr),
        .wr_data (b_wr_data)
    );

    hv_rotate i_rotate (
        .ex      (ex.dp),
        .src     (b_data),
        .operand (operand)
    );

    hdc_execute i_execute (
        .clk       (clk),
        .rst       (rst),
        .ex        (ex.dp),
        .mem_data  (mem_data),
        .a_data    (a_data),
        .operand   (operand),
        .a_wr      (a_wr),
        .b_wr      (b_wr),
        .b_wr_data (b_wr_data),
        .wb_wr     (wb_wr),
        .wb_addr   (wb_addr),
        .store     (store),
        .result    (result),
        .last      (last)
    );

endmodule

// File: verif/tb_hdc_core.sv
`timescale 1ns/1ps

module tb_hdc_core;

    localparam int TIMEOUT_CYCLES = 2000;

    logic               clk;
    logic               rst;
    logic               run;
    logic               instr_valid;
    hdc_pkg::instr_t    instr;
    logic               item_wr;
    hdc_pkg::mem_addr_t item_addr;
    hdc_pkg::hv_t       item_data;
    logic               store;
    hdc_pkg::hv_t       result;
    logic               last;

    // reference model state
    hdc_pkg::hv_t       mem_model [hdc_pkg::MEM_DEPTH];
    hdc_pkg::hv_t       a_model [hdc_pkg::THREADS];
    hdc_pkg::hv_t       b_model [hdc_pkg::THREADS];
    int                 thr;
    logic               wb_pend;
    hdc_pkg::mem_addr_t wb_pend_addr;
    hdc_pkg::hv_t       wb_pend_data;

    // expected outputs delayed to the edge where the DUT shows them
    logic               exp_store_n;
    logic               exp_store_d1;
    logic               exp_store_d2;
    logic               exp_last_n;
    logic               exp_last_d1;
    logic               exp_last_d2;
    hdc_pkg::hv_t       exp_result_n;
    hdc_pkg::hv_t       exp_result_d1;
    hdc_pkg::hv_t       exp_result_d2;

    hdc_pkg::mem_addr_t item_tab [hdc_pkg::THREADS];
    hdc_pkg::hv_t       item_val [hdc_pkg::THREADS];
    hdc_pkg::hv_t       ext_val;
    hdc_pkg::mem_addr_t wb_new_addr;
    int                 seed;
    int                 cycles;

    hdc_core i_dut (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .instr_valid (instr_valid),
        .instr       (instr),
        .item_wr     (item_wr),
        .item_addr   (item_addr),
        .item_data   (item_data),
        .store       (store),
        .result      (result),
        .last        (last)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_store_d1  <= 1'b0;
            exp_store_d2  <= 1'b0;
            exp_last_d1   <= 1'b0;
            exp_last_d2   <= 1'b0;
            exp_result_d1 <= '0;
            exp_result_d2 <= '0;
        end else begin
            exp_store_d1  <= exp_store_n;
            exp_store_d2  <= exp_store_d1;
            exp_last_d1   <= exp_last_n;
            exp_last_d2   <= exp_last_d1;
            exp_result_d1 <= exp_result_n;
            exp_result_d2 <= exp_result_d1;
        end
    end

    a_store_match: assert property (@(posedge clk) disable iff (rst) store === exp_store_d2)
        else report_error($sformatf("store is %0b, expected %0b",
            $sampled(store), $sampled(exp_store_d2)));

    a_result_match: assert property (@(posedge clk) disable iff (rst) result === exp_result_d2)
        else report_error($sformatf("result is %h, expected %h",
            $sampled(result), $sampled(exp_result_d2)));

    a_last_match: assert property (@(posedge clk) disable iff (rst) last === exp_last_d2)
        else report_error($sformatf("last is %0b, expected %0b",
            $sampled(last), $sampled(exp_last_d2)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not finish within %0d cycles",
                TIMEOUT_CYCLES);
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "output check failed");
    endtask

    function automatic hdc_pkg::hv_t rotate_left(input hdc_pkg::hv_t v, input int k);
        hdc_pkg::hv_t r;
        for (int i = 0; i < hdc_pkg::HV_DIM; i++) begin
            r[(i + k) % hdc_pkg::HV_DIM] = v[i];
        end
        return r;
    endfunction

    // op_bit below zero gives a nop
    function automatic hdc_pkg::instr_t encode_instr(input logic addr_form, input logic perm,
            input int op_bit, input int low);
        hdc_pkg::instr_t ins;
        ins = hdc_pkg::instr_t'(low) & 16'h01ff;
        ins[hdc_pkg::BIT_ADDR] = addr_form;
        ins[hdc_pkg::BIT_PERMUTE] = perm;
        if (op_bit >= 0) begin
            ins[op_bit] = 1'b1;
        end
        return ins;
    endfunction

    // one clock of stimulus mirrored into the model
    task automatic drive_cycle(input logic run_in, input logic valid, input hdc_pkg::instr_t ins,
            input logic wr, input hdc_pkg::mem_addr_t waddr, input hdc_pkg::hv_t wdata);
        hdc_pkg::hv_t       rd_val;
        hdc_pkg::hv_t       opnd;
        hdc_pkg::mem_addr_t low;
        @(posedge clk);
        #2;
        run          = run_in;
        instr_valid  = valid;
        instr        = ins;
        item_wr      = wr;
        item_addr    = waddr;
        item_data    = wdata;
        exp_store_n  = 1'b0;
        exp_last_n   = 1'b0;
        exp_result_n = '0;
        // the read sees the memory before this edge's write
        low    = ins[hdc_pkg::ADDR_W-1:0];
        rd_val = mem_model[low];
        // a write-back executing now wins over the external write
        if (wb_pend) begin
            mem_model[wb_pend_addr] = wb_pend_data;
        end else if (wr) begin
            mem_model[waddr] = wdata;
        end
        wb_pend = 1'b0;
        if (!run_in) begin
            for (int t = 0; t < hdc_pkg::THREADS; t++) begin
                a_model[t] = '0;
                b_model[t] = '0;
            end
            thr = 0;
        end else if (valid) begin
            opnd = b_model[thr];
            if (ins[hdc_pkg::BIT_PERMUTE]) begin
                opnd = rotate_left(b_model[thr], int'(ins[hdc_pkg::ROT_W-1:0]));
            end
            if (ins[hdc_pkg::BIT_ADDR]) begin
                if (ins[hdc_pkg::BIT_LOAD_XOR]) begin
                    b_model[thr] = rd_val;
                end else if (ins[hdc_pkg::BIT_STORE_WB]) begin
                    wb_pend      = 1'b1;
                    wb_pend_addr = low;
                    wb_pend_data = opnd;
                end
            end else if (ins[hdc_pkg::BIT_LOAD_XOR]) begin
                b_model[thr] = a_model[thr] ^ opnd;
            end else if (ins[hdc_pkg::BIT_STORE_WB]) begin
                exp_store_n  = 1'b1;
                exp_result_n = opnd;
            end else if (ins[hdc_pkg::BIT_MOVE]) begin
                a_model[thr] = opnd;
            end else if (ins[hdc_pkg::BIT_LAST]) begin
                exp_last_n = 1'b1;
            end
            thr = (thr == hdc_pkg::THREADS - 1) ? 0 : thr + 1;
        end
    endtask

    task automatic issue_instr(input hdc_pkg::instr_t ins);
        drive_cycle(1'b1, 1'b1, ins, 1'b0, '0, '0);
    endtask

    task automatic write_item(input hdc_pkg::mem_addr_t addr, input hdc_pkg::hv_t data);
        drive_cycle(1'b1, 1'b0, '0, 1'b1, addr, data);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b1, 1'b0, '0, 1'b0, '0, '0);
    endtask

    initial begin
        rst          = 1'b1;
        run          = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        item_wr      = 1'b0;
        item_addr    = '0;
        item_data    = '0;
        exp_store_n  = 1'b0;
        exp_last_n   = 1'b0;
        exp_result_n = '0;
        wb_pend      = 1'b0;
        thr          = 0;
        cycles       = 0;
        seed         = 11816;
        wb_new_addr  = 9'h1a5;
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            a_model[t]  = '0;
            b_model[t]  = '0;
            item_tab[t] = hdc_pkg::mem_addr_t'(t * 37 + 5);
            item_val[t] = {$random(seed), $random(seed)};
        end
        ext_val = {$random(seed), $random(seed)};
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        run = 1'b1;

        // quiet outputs after reset
        repeat (3) idle_cycle();

        // fill the memory and load and store one vector per thread
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            write_item(item_tab[t], item_val[t]);
        end
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b1, 1'b0, hdc_pkg::BIT_LOAD_XOR, int'(item_tab[t])));
        end
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_STORE_WB, 0));
        end

        // binding X xor Y with one round of ten per step
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b1, 1'b0, hdc_pkg::BIT_LOAD_XOR, int'(item_tab[t])));
        end
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_MOVE, 0));
        end
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b1, 1'b0, hdc_pkg::BIT_LOAD_XOR,
                int'(item_tab[(t + 3) % hdc_pkg::THREADS])));
        end
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_LOAD_XOR, 0));
        end
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_STORE_WB, 0));
        end

        // permuted stores with a different amount per thread
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            issue_instr(encode_instr(1'b0, 1'b1, hdc_pkg::BIT_STORE_WB, 3 * t + 1));
        end

        // write-back of a permuted B drops the colliding external write
        issue_instr(encode_instr(1'b1, 1'b1, hdc_pkg::BIT_STORE_WB, int'(wb_new_addr)));
        drive_cycle(1'b1, 1'b1, '0, 1'b1, item_tab[3], ext_val);
        issue_instr(encode_instr(1'b1, 1'b0, hdc_pkg::BIT_LOAD_XOR, int'(wb_new_addr)));
        issue_instr(encode_instr(1'b1, 1'b0, hdc_pkg::BIT_LOAD_XOR, int'(item_tab[3])));
        repeat (8) issue_instr('0);
        issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_STORE_WB, 0));
        issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_STORE_WB, 0));

        // last pulse and then one cycle with run low
        issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_LAST, 0));
        idle_cycle();
        drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, '0);
        issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_STORE_WB, 0));
        issue_instr(encode_instr(1'b1, 1'b0, hdc_pkg::BIT_LOAD_XOR, int'(item_tab[5])));
        repeat (9) issue_instr('0);
        issue_instr(encode_instr(1'b0, 1'b0, hdc_pkg::BIT_STORE_WB, 0));

        repeat (3) idle_cycle();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: flist.f
rtl/hdc_pkg.sv
rtl/hdc_exec_if.sv
rtl/item_memory.sv
rtl/thread_regbank.sv
rtl/hv_rotate.sv
rtl/hdc_execute.sv
rtl/hdc_decode.sv
rtl/hdc_core.sv
verif/tb_hdc_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_hdc_core
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
